/* div_step_counter.sv */
`timescale 1ns/1ps

module div_step_counter (
  input  logic clk,
  input  logic rst,
  input  logic div_start,
  output logic div_busy,
  output logic div_last
);
  import rv_exec_pkg::*;

  step_t count;
  logic  busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (div_start) begin
      busy  <= 1'b1;
      count <= step_t'(DIV_STEPS - 1);
    end else if (busy) begin
      if (count == '0) busy <= 1'b0;
      else count <= count - 1'b1;
    end
  end

  assign div_busy = busy;
  assign div_last = busy && (count == '0);

  a_no_restart: assert property (@(posedge clk) disable iff (rst) div_start |-> !busy);

endmodule

/* exec_alu.sv */
`timescale 1ns/1ps

module exec_alu (
  input  rv_exec_pkg::exec_func_e func,
  input  rv_exec_pkg::xlen_t      src1,
  input  rv_exec_pkg::xlen_t      src2,
  input  rv_exec_pkg::xlen_t      imm,
  input  rv_exec_pkg::pc_t        pc,
  output rv_exec_pkg::xlen_t      alu_value,
  output rv_exec_pkg::pc_t        alu_dnpc,
  output logic                    alu_illegal
);
  import rv_exec_pkg::*;

  logic [5:0]  shamt;
  logic [4:0]  shamt_w;
  logic [31:0] sllw_res;
  pc_t         seq_pc;
  pc_t         br_pc;
  xlen_t       jalr_tgt;

  assign shamt    = src2[5:0];
  assign shamt_w  = src2[4:0];
  assign sllw_res = src1[31:0] << shamt_w;
  assign seq_pc   = pc + 64'd4;
  assign br_pc    = pc + imm;
  assign jalr_tgt = src1 + imm;

  always_comb begin
    alu_value   = '0;
    alu_dnpc    = seq_pc;
    alu_illegal = 1'b0;
    case (func)
      // register-register
      func_add:  alu_value = src1 + src2;
      func_sub:  alu_value = src1 - src2;
      func_and:  alu_value = src1 & src2;
      func_or:   alu_value = src1 | src2;
      func_xor:  alu_value = src1 ^ src2;
      func_slt:  alu_value = {63'd0, $signed(src1) < $signed(src2)};
      func_sltu: alu_value = {63'd0, src1 < src2};
      func_sll:  alu_value = src1 << shamt;
      func_srl:  alu_value = src1 >> shamt;
      func_sra:  alu_value = $signed(src1) >>> shamt;
      // word ops, low 32 bits then sign extend
      func_addw: alu_value = sext_word(src1[31:0] + src2[31:0]);
      func_subw: alu_value = sext_word(src1[31:0] - src2[31:0]);
      func_sllw: alu_value = sext_word(sllw_res);
      // branches only move dnpc
      func_beq:  alu_dnpc = (src1 == src2) ? br_pc : seq_pc;
      func_bne:  alu_dnpc = (src1 != src2) ? br_pc : seq_pc;
      func_blt:  alu_dnpc = ($signed(src1) < $signed(src2)) ? br_pc : seq_pc;
      func_bge:  alu_dnpc = ($signed(src1) >= $signed(src2)) ? br_pc : seq_pc;
      func_bltu: alu_dnpc = (src1 < src2) ? br_pc : seq_pc;
      func_bgeu: alu_dnpc = (src1 >= src2) ? br_pc : seq_pc;
      func_jal: begin
        alu_value = seq_pc;
        alu_dnpc  = br_pc;
      end
      func_jalr: begin
        alu_value = seq_pc;
        alu_dnpc  = {jalr_tgt[63:1], 1'b0};
      end
      func_lui:   alu_value = imm;
      func_auipc: alu_value = br_pc;
      // value comes from lsu or divider
      func_ld, func_lw, func_lwu, func_lh, func_lhu, func_lb, func_lbu,
      func_sd, func_sw, func_sh, func_sb,
      func_div, func_divu, func_rem, func_remu: ;
      default: alu_illegal = 1'b1;
    endcase
  end

endmodule

/* exec_fsm.sv */
`timescale 1ns/1ps

module exec_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    q_valid,
  input  rv_exec_pkg::exec_func_e q_func,
  input  logic                    res_credit,
  output logic                    q_pop,
  output logic                    mem_rd_en,
  output logic                    mem_wr_en,
  output logic                    div_start,
  input  logic                    div_last,
  input  rv_exec_pkg::xlen_t      alu_value,
  input  rv_exec_pkg::pc_t        alu_dnpc,
  input  logic                    alu_illegal,
  input  rv_exec_pkg::xlen_t      load_value,
  input  rv_exec_pkg::xlen_t      div_value,
  input  rv_exec_pkg::pc_t        q_pc,
  output logic                    res_valid,
  output rv_exec_pkg::xlen_t      res_value,
  output rv_exec_pkg::pc_t        res_dnpc,
  output logic                    res_illegal
);
  import rv_exec_pkg::*;

  fsm_state_e state;
  fsm_state_e state_n;
  cred_t      credits;
  logic       can_pop;
  logic       emit;
  logic       cls_div;
  logic       cls_store;
  xlen_t      hold_value;
  pc_t        hold_dnpc;
  logic       hold_illegal;

  // head is consumed in the pop cycle, datapath latches what it needs
  assign can_pop   = (state == st_idle) && q_valid && (credits != '0);
  assign q_pop     = can_pop;
  assign mem_rd_en = can_pop && is_load(q_func);
  assign mem_wr_en = can_pop && is_store(q_func);
  assign div_start = can_pop && is_div(q_func);
  assign emit      = (state == st_alu);

  always_comb begin
    state_n = state;
    case (state)
      st_idle: begin
        if (can_pop) begin
          if (is_load(q_func) || is_store(q_func)) state_n = st_mem;
          else if (is_div(q_func)) state_n = st_div;
          else state_n = st_alu;
        end
      end
      st_div:  if (div_last) state_n = st_mem;
      // late value capture for loads and divides
      st_mem:  state_n = st_alu;
      st_alu:  state_n = st_emit;
      default: state_n = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      credits   <= cred_t'(RES_CREDITS);
      res_valid <= 1'b0;
    end else begin
      state     <= state_n;
      credits   <= credits - cred_t'(emit) + cred_t'(res_credit);
      res_valid <= emit;
    end
  end

  always_ff @(posedge clk) begin
    if (can_pop) begin
      cls_div      <= is_div(q_func);
      cls_store    <= is_store(q_func);
      hold_value   <= alu_value;
      hold_illegal <= alu_illegal;
      // non-alu ops fall through to pc+4
      hold_dnpc    <= (is_load(q_func) || is_store(q_func) || is_div(q_func)) ?
                      q_pc + 64'd4 : alu_dnpc;
    end else if (state == st_mem) begin
      hold_value <= cls_store ? '0 : (cls_div ? div_value : load_value);
    end
  end

  // record loaded on the way into st_emit
  always_ff @(posedge clk) begin
    if (emit) begin
      res_value   <= hold_value;
      res_dnpc    <= hold_dnpc;
      res_illegal <= hold_illegal;
    end
  end

  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credits <= cred_t'(RES_CREDITS));

endmodule

/* exec_top.sv */
`timescale 1ns/1ps

module exec_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  rv_exec_pkg::exec_func_e in_func,
  input  rv_exec_pkg::xlen_t      in_src1,
  input  rv_exec_pkg::xlen_t      in_src2,
  input  rv_exec_pkg::xlen_t      in_imm,
  input  rv_exec_pkg::pc_t        in_pc,
  output logic                    in_credit,
  output logic                    res_valid,
  output rv_exec_pkg::xlen_t      res_value,
  output rv_exec_pkg::pc_t        res_dnpc,
  output logic                    res_illegal,
  input  logic                    res_credit
);
  import rv_exec_pkg::*;

  logic       q_valid;
  logic       q_pop;
  exec_func_e q_func;
  xlen_t      q_src1;
  xlen_t      q_src2;
  xlen_t      q_imm;
  pc_t        q_pc;
  logic       mem_rd_en;
  logic       mem_wr_en;
  logic       div_start;
  logic       div_busy;
  logic       div_last;
  xlen_t      alu_value;
  pc_t        alu_dnpc;
  logic       alu_illegal;
  xlen_t      load_value;
  xlen_t      div_value;

  op_queue u_queue (
    .clk, .rst, .in_valid, .in_func, .in_src1, .in_src2, .in_imm, .in_pc,
    .q_pop, .q_valid, .q_func, .q_src1, .q_src2, .q_imm, .q_pc, .in_credit
  );

  exec_fsm u_fsm (
    .clk, .rst, .q_valid, .q_func, .res_credit, .q_pop, .mem_rd_en, .mem_wr_en,
    .div_start, .div_last, .alu_value, .alu_dnpc, .alu_illegal, .load_value,
    .div_value, .q_pc, .res_valid, .res_value, .res_dnpc, .res_illegal
  );

  div_step_counter u_steps (.clk, .rst, .div_start, .div_busy, .div_last);

  exec_alu u_alu (
    .func(q_func), .src1(q_src1), .src2(q_src2), .imm(q_imm), .pc(q_pc),
    .alu_value, .alu_dnpc, .alu_illegal
  );

  load_store_unit u_lsu (
    .clk, .rst, .func(q_func), .base(q_src1), .imm(q_imm), .store_data(q_src2),
    .mem_rd_en, .mem_wr_en, .load_value
  );

  iter_divider u_div (
    .clk, .rst, .div_start, .func(q_func), .dividend(q_src1), .divisor(q_src2),
    .div_last, .div_value
  );

  // in-order, single slot: nothing leaves the queue while dividing
  a_no_pop_in_div: assert property (@(posedge clk) disable iff (rst) div_busy |-> !q_pop);

endmodule

/* iter_divider.sv */
`timescale 1ns/1ps

module iter_divider (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    div_start,
  input  rv_exec_pkg::exec_func_e func,
  input  rv_exec_pkg::xlen_t      dividend,
  input  rv_exec_pkg::xlen_t      divisor,
  input  logic                    div_last,
  output rv_exec_pkg::xlen_t      div_value
);
  import rv_exec_pkg::*;

  logic        running;
  exec_func_e  op_func;
  logic        neg_q;
  logic        neg_r;
  logic        by_zero;
  logic        ovf;
  logic        signed_in;
  xlen_t       mag_a_in;
  xlen_t       mag_b_in;
  xlen_t       orig_a;
  xlen_t       mag_b;
  xlen_t       quo;
  xlen_t       rem;
  logic [64:0] trial;
  logic [64:0] diff;
  xlen_t       q_fix;
  xlen_t       r_fix;

  assign signed_in = (func == func_div) || (func == func_rem);
  assign mag_a_in  = (signed_in && dividend[63]) ? -dividend : dividend;
  assign mag_b_in  = (signed_in && divisor[63]) ? -divisor : divisor;

  always_ff @(posedge clk) begin
    if (rst) running <= 1'b0;
    else if (div_start) running <= 1'b1;
    else if (div_last) running <= 1'b0;
  end

  // one quotient bit per step, msb first
  assign trial = {rem, quo[63]};
  assign diff  = trial - {1'b0, mag_b};

  always_ff @(posedge clk) begin
    if (div_start) begin
      op_func <= func;
      orig_a  <= dividend;
      mag_b   <= mag_b_in;
      quo     <= mag_a_in;
      rem     <= '0;
      neg_q   <= signed_in && (dividend[63] ^ divisor[63]);
      neg_r   <= signed_in && dividend[63];
      by_zero <= (divisor == '0);
      ovf     <= signed_in && (dividend == {1'b1, 63'd0}) && (divisor == '1);
    end else if (running) begin
      if (!diff[64]) begin
        rem <= diff[63:0];
        quo <= {quo[62:0], 1'b1};
      end else begin
        rem <= trial[63:0];
        quo <= {quo[62:0], 1'b0};
      end
    end
  end

  // sign fixup and riscv special cases
  always_comb begin
    q_fix = neg_q ? -quo : quo;
    r_fix = neg_r ? -rem : rem;
    if (by_zero) begin
      q_fix = '1;
      r_fix = orig_a;
    end else if (ovf) begin
      q_fix = orig_a;
      r_fix = '0;
    end
  end

  assign div_value = (op_func == func_div || op_func == func_divu) ? q_fix : r_fix;

endmodule

/* load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_exec_pkg::exec_func_e func,
  input  rv_exec_pkg::xlen_t      base,
  input  rv_exec_pkg::xlen_t      imm,
  input  rv_exec_pkg::xlen_t      store_data,
  input  logic                    mem_rd_en,
  input  logic                    mem_wr_en,
  output rv_exec_pkg::xlen_t      load_value
);
  import rv_exec_pkg::*;

  xlen_t      mem [MEM_WORDS];
  xlen_t      addr;
  mem_index_t idx;
  logic [2:0] off;
  logic [7:0] size_mask;
  logic [7:0] wmask;
  xlen_t      wdata;
  xlen_t      rd_word;
  logic [2:0] rd_off;
  exec_func_e rd_func;
  xlen_t      rd_shift;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // word index wraps over the 256 entries
  assign addr = base + imm;
  assign idx  = addr[10:3];
  assign off  = addr[2:0];

  always_comb begin
    case (func)
      func_sd: size_mask = 8'hff;
      func_sw: size_mask = 8'h0f;
      func_sh: size_mask = 8'h03;
      func_sb: size_mask = 8'h01;
      default: size_mask = 8'h00;
    endcase
  end

  assign wmask = size_mask << off;
  assign wdata = store_data << {off, 3'b000};

  // byte lane merge
  always @(posedge clk) begin
    if (mem_wr_en) begin
      for (int b = 0; b < 8; b++) begin
        if (wmask[b]) mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rd_en) begin
      rd_word <= mem[idx];
      rd_off  <= off;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) rd_func <= func_none;
    else if (mem_rd_en) rd_func <= func;
  end

  assign rd_shift = rd_word >> {rd_off, 3'b000};

  always_comb begin
    case (rd_func)
      func_lw:  load_value = sext_word(rd_shift[31:0]);
      func_lwu: load_value = {32'd0, rd_shift[31:0]};
      func_lh:  load_value = {{48{rd_shift[15]}}, rd_shift[15:0]};
      func_lhu: load_value = {48'd0, rd_shift[15:0]};
      func_lb:  load_value = {{56{rd_shift[7]}}, rd_shift[7:0]};
      func_lbu: load_value = {56'd0, rd_shift[7:0]};
      default:  load_value = rd_shift;
    endcase
  end

endmodule

/* op_queue.sv */
`timescale 1ns/1ps

module op_queue (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  rv_exec_pkg::exec_func_e in_func,
  input  rv_exec_pkg::xlen_t      in_src1,
  input  rv_exec_pkg::xlen_t      in_src2,
  input  rv_exec_pkg::xlen_t      in_imm,
  input  rv_exec_pkg::pc_t        in_pc,
  input  logic                    q_pop,
  output logic                    q_valid,
  output rv_exec_pkg::exec_func_e q_func,
  output rv_exec_pkg::xlen_t      q_src1,
  output rv_exec_pkg::xlen_t      q_src2,
  output rv_exec_pkg::xlen_t      q_imm,
  output rv_exec_pkg::pc_t        q_pc,
  output logic                    in_credit
);
  import rv_exec_pkg::*;

  exec_func_e func_q [QUEUE_DEPTH];
  xlen_t      src1_q [QUEUE_DEPTH];
  xlen_t      src2_q [QUEUE_DEPTH];
  xlen_t      imm_q  [QUEUE_DEPTH];
  pc_t        pc_q   [QUEUE_DEPTH];
  qptr_t      wr_ptr;
  qptr_t      rd_ptr;
  qcnt_t      count;

  function automatic qptr_t ptr_next(qptr_t p);
    return (p == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // entry storage
  always_ff @(posedge clk) begin
    if (in_valid) begin
      func_q[wr_ptr] <= in_func;
      src1_q[wr_ptr] <= in_src1;
      src2_q[wr_ptr] <= in_src2;
      imm_q[wr_ptr]  <= in_imm;
      pc_q[wr_ptr]   <= in_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) wr_ptr <= ptr_next(wr_ptr);
      if (q_pop) rd_ptr <= ptr_next(rd_ptr);
      count <= count + qcnt_t'(in_valid) - qcnt_t'(q_pop);
    end
  end

  assign q_valid   = (count != '0);
  assign q_func    = func_q[rd_ptr];
  assign q_src1    = src1_q[rd_ptr];
  assign q_src2    = src2_q[rd_ptr];
  assign q_imm     = imm_q[rd_ptr];
  assign q_pc      = pc_q[rd_ptr];
  // one credit back per slot freed
  assign in_credit = q_pop & q_valid;

  // upstream spent a credit it did not hold
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> (count != qcnt_t'(QUEUE_DEPTH)));
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    q_pop |-> q_valid);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the execute block testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_exec_top -o tb_exec_top_sim > build.log 2>&1 \
  && ./obj_dir/tb_exec_top_sim > sim.log 2>&1 \
  && grep -q "^TEST PASSED$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

exit 0

/* rv_exec_pkg.sv */
package rv_exec_pkg;

  localparam int XLEN        = 64;
  localparam int QUEUE_DEPTH = 2;
  localparam int RES_CREDITS = 2;
  localparam int MEM_WORDS   = 256;
  localparam int DIV_STEPS   = 64;

  // derived widths
  localparam int QPTR_W  = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W  = $clog2(QUEUE_DEPTH + 1);
  localparam int CRED_W  = $clog2(RES_CREDITS + 1);
  localparam int STEP_W  = $clog2(DIV_STEPS);
  localparam int MIDX_W  = $clog2(MEM_WORDS);

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [63:0]       pc_t;
  typedef logic [MIDX_W-1:0] mem_index_t;
  typedef logic [QPTR_W-1:0] qptr_t;
  typedef logic [QCNT_W-1:0] qcnt_t;
  typedef logic [CRED_W-1:0] cred_t;
  typedef logic [STEP_W-1:0] step_t;

  typedef enum logic [5:0] {
    func_none = 6'd0,
    func_add, func_sub, func_and, func_or, func_xor,
    func_slt, func_sltu, func_sll, func_srl, func_sra,
    func_addw, func_subw, func_sllw,
    func_beq, func_bne, func_blt, func_bge, func_bltu, func_bgeu,
    func_jal, func_jalr, func_lui, func_auipc,
    func_ld, func_lw, func_lwu, func_lh, func_lhu, func_lb, func_lbu,
    func_sd, func_sw, func_sh, func_sb,
    func_div, func_divu, func_rem, func_remu
  } exec_func_e;

  typedef enum logic [2:0] {
    st_idle,
    st_alu,
    st_mem,
    st_div,
    st_emit
  } fsm_state_e;

  // operation classes
  function automatic logic is_load(exec_func_e f);
    return f inside {func_ld, func_lw, func_lwu, func_lh, func_lhu, func_lb, func_lbu};
  endfunction

  function automatic logic is_store(exec_func_e f);
    return f inside {func_sd, func_sw, func_sh, func_sb};
  endfunction

  function automatic logic is_div(exec_func_e f);
    return f inside {func_div, func_divu, func_rem, func_remu};
  endfunction

  function automatic xlen_t sext_word(logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

endpackage

/* tb_exec_model.svh */
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

localparam int NUM_FUNCS = int'(func_remu) + 1;

typedef struct packed {
  xlen_t value;
  pc_t   dnpc;
  logic  illegal;
} exp_rec_t;

logic [31:0] rng_state = 32'h7ae3_598b;
xlen_t       model_mem [MEM_WORDS];

function automatic logic [31:0] xorshift32();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

function automatic xlen_t rand64();
  logic [31:0] hi;
  logic [31:0] lo;
  hi = xorshift32();
  lo = xorshift32();
  return {hi, lo};
endfunction

// corner values mixed with wide random ones
function automatic xlen_t pick_operand();
  logic [31:0] r;
  r = xorshift32();
  case (r[2:0])
    3'd0: return '0;
    3'd1: return '1;
    3'd2: return {1'b1, 63'd0};
    3'd3: return {60'd0, r[7:4]};
    3'd4: return {{32{r[31]}}, r};
    default: return rand64();
  endcase
endfunction

function automatic int access_bytes(exec_func_e f);
  case (f)
    func_ld, func_sd: return 8;
    func_lw, func_lwu, func_sw: return 4;
    func_lh, func_lhu, func_sh: return 2;
    func_lb, func_lbu, func_sb: return 1;
    default: return 0;
  endcase
endfunction

task automatic gen_op(output exec_func_e f, output xlen_t s1, output xlen_t s2,
                      output xlen_t imm, output pc_t pc);
  logic [31:0] r;
  logic [5:0]  code;
  int          nbytes;
  int          off;
  xlen_t       addr;
  r = xorshift32();
  // extra weight on memory ops so loads hit stored bytes
  if (r[1:0] == 2'd0) code = 6'(int'(func_ld) + int'(r[31:8] % 24'd11));
  else code = 6'(r[31:8] % 24'(NUM_FUNCS));
  f   = exec_func_e'(code);
  s1  = pick_operand();
  s2  = pick_operand();
  r   = xorshift32();
  imm = {{52{r[11]}}, r[11:0]};
  pc  = rand64();
  pc[1:0] = 2'b00;
  if (f == func_lui) imm = {{32{r[31]}}, r[31:12], 12'd0};
  if (f inside {func_beq, func_bne, func_blt, func_bge, func_bltu, func_bgeu}) begin
    if (r[12]) s2 = s1;
    imm[0] = 1'b0;
  end
  nbytes = access_bytes(f);
  if (nbytes != 0) begin
    // aligned address in the low 16 words
    r    = xorshift32();
    off  = int'(r[6:4]) & ~(nbytes - 1);
    addr = xlen_t'(int'(r[3:0]) * 8 + off);
    imm  = {{57{r[13]}}, r[13:7]};
    s1   = addr - imm;
  end
  if (f inside {func_div, func_divu, func_rem, func_remu}) begin
    r = xorshift32();
    if (r[1:0] == 2'd0) s2 = '0;
    if (r[1:0] == 2'd1) begin
      s1 = {1'b1, 63'd0};
      s2 = '1;
    end
  end
endtask

function automatic xlen_t mem_read(xlen_t addr, int nbytes, logic sign);
  xlen_t word;
  xlen_t val;
  int    lo;
  word = model_mem[addr[10:3]];
  lo   = int'(addr[2:0]);
  val  = '0;
  for (int i = 0; i < nbytes; i++) val[i*8 +: 8] = word[(lo+i)*8 +: 8];
  if (sign) begin
    for (int b = nbytes * 8; b < 64; b++) val[b] = val[nbytes*8-1];
  end
  return val;
endfunction

task automatic mem_write(xlen_t addr, int nbytes, xlen_t data);
  int lo;
  lo = int'(addr[2:0]);
  for (int i = 0; i < nbytes; i++) model_mem[addr[10:3]][(lo+i)*8 +: 8] = data[i*8 +: 8];
endtask

task automatic model_op(input exec_func_e f, input xlen_t s1, input xlen_t s2,
                        input xlen_t imm, input pc_t pc, output exp_rec_t rec);
  xlen_t       addr;
  xlen_t       tgt;
  logic [31:0] w32;
  logic        taken;
  logic        ovf;
  addr  = s1 + imm;
  taken = 1'b0;
  ovf   = (s1 == {1'b1, 63'd0}) && (s2 == '1);
  rec.value   = '0;
  rec.dnpc    = pc + 64'd4;
  rec.illegal = 1'b0;
  case (f)
    func_add:  rec.value = s1 + s2;
    func_sub:  rec.value = s1 - s2;
    func_and:  rec.value = s1 & s2;
    func_or:   rec.value = s1 | s2;
    func_xor:  rec.value = s1 ^ s2;
    func_slt:  rec.value = ($signed(s1) < $signed(s2)) ? 64'd1 : 64'd0;
    func_sltu: rec.value = (s1 < s2) ? 64'd1 : 64'd0;
    func_sll:  rec.value = s1 << s2[5:0];
    func_srl:  rec.value = s1 >> s2[5:0];
    func_sra:  rec.value = xlen_t'($signed(s1) >>> s2[5:0]);
    func_addw, func_subw, func_sllw: begin
      if (f == func_addw) w32 = s1[31:0] + s2[31:0];
      else if (f == func_subw) w32 = s1[31:0] - s2[31:0];
      else w32 = s1[31:0] << s2[4:0];
      rec.value = {{32{w32[31]}}, w32};
    end
    func_beq:  taken = (s1 == s2);
    func_bne:  taken = (s1 != s2);
    func_blt:  taken = ($signed(s1) < $signed(s2));
    func_bge:  taken = ($signed(s1) >= $signed(s2));
    func_bltu: taken = (s1 < s2);
    func_bgeu: taken = (s1 >= s2);
    func_jal: begin
      rec.value = pc + 64'd4;
      rec.dnpc  = pc + imm;
    end
    func_jalr: begin
      tgt       = s1 + imm;
      tgt[0]    = 1'b0;
      rec.value = pc + 64'd4;
      rec.dnpc  = tgt;
    end
    func_lui:   rec.value = imm;
    func_auipc: rec.value = pc + imm;
    func_ld:  rec.value = mem_read(addr, 8, 1'b0);
    func_lw:  rec.value = mem_read(addr, 4, 1'b1);
    func_lwu: rec.value = mem_read(addr, 4, 1'b0);
    func_lh:  rec.value = mem_read(addr, 2, 1'b1);
    func_lhu: rec.value = mem_read(addr, 2, 1'b0);
    func_lb:  rec.value = mem_read(addr, 1, 1'b1);
    func_lbu: rec.value = mem_read(addr, 1, 1'b0);
    func_sd, func_sw, func_sh, func_sb: mem_write(addr, access_bytes(f), s2);
    // riscv rules for zero divisor and overflow
    func_divu: rec.value = (s2 == '0) ? '1 : s1 / s2;
    func_remu: rec.value = (s2 == '0) ? s1 : s1 % s2;
    func_div: begin
      if (s2 == '0) rec.value = '1;
      else if (ovf) rec.value = s1;
      else rec.value = xlen_t'($signed(s1) / $signed(s2));
    end
    func_rem: begin
      if (s2 == '0) rec.value = s1;
      else if (ovf) rec.value = '0;
      else rec.value = xlen_t'($signed(s1) % $signed(s2));
    end
    default: rec.illegal = 1'b1;
  endcase
  if (taken) rec.dnpc = pc + imm;
endtask

`endif

/* tb_exec_top.sv */
`timescale 1ns/1ps

module tb_exec_top;
  import rv_exec_pkg::*;

  localparam int NUM_OPS       = 600;
  localparam int CYCLES_PER_OP = 80;
  localparam int CLK_PERIOD    = 8;
  localparam int WATCHDOG_NS   = NUM_OPS * CYCLES_PER_OP * CLK_PERIOD;

  logic       clk;
  logic       rst;
  logic       in_valid;
  exec_func_e in_func;
  xlen_t      in_src1;
  xlen_t      in_src2;
  xlen_t      in_imm;
  pc_t        in_pc;
  logic       in_credit;
  logic       res_valid;
  xlen_t      res_value;
  pc_t        res_dnpc;
  logic       res_illegal;
  logic       res_credit;

  `include "tb_exec_model.svh"

  exp_rec_t exp_q [$];
  int       credit_delays [$];
  int       up_credits    = QUEUE_DEPTH;
  int       block_credits = RES_CREDITS;
  int       issued        = 0;
  int       received      = 0;

  exec_top dut (
    .clk, .rst, .in_valid, .in_func, .in_src1, .in_src2, .in_imm, .in_pc,
    .in_credit, .res_valid, .res_value, .res_dnpc, .res_illegal, .res_credit
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_result();
    exp_rec_t want;
    if (res_valid) begin
      assert (block_credits > 0)
        else stop_on_error($sformatf("res_valid at %0t while no result credit was held", $time));
      assert (exp_q.size() > 0)
        else stop_on_error($sformatf("result at %0t with no operation outstanding", $time));
      want = exp_q.pop_front();
      assert (res_value == want.value)
        else stop_on_error($sformatf("MISMATCH at %0t: result %0d value %h, expected %h",
                                     $time, received, res_value, want.value));
      assert (res_dnpc == want.dnpc)
        else stop_on_error($sformatf("MISMATCH at %0t: result %0d dnpc %h, expected %h",
                                     $time, received, res_dnpc, want.dnpc));
      assert (res_illegal == want.illegal)
        else stop_on_error($sformatf("MISMATCH at %0t: result %0d illegal %b, expected %b",
                                     $time, received, res_illegal, want.illegal));
      block_credits--;
      received++;
      credit_delays.push_back(int'(xorshift32() % 32'd6));
    end
  endtask

  task automatic drive_upstream();
    exec_func_e  f;
    xlen_t       s1;
    xlen_t       s2;
    xlen_t       imm;
    pc_t         pc;
    exp_rec_t    rec;
    logic [31:0] r;
    r = xorshift32();
    if (up_credits > 0 && issued < NUM_OPS && r[0]) begin
      gen_op(f, s1, s2, imm, pc);
      model_op(f, s1, s2, imm, pc, rec);
      exp_q.push_back(rec);
      in_valid = 1'b1;
      in_func  = f;
      in_src1  = s1;
      in_src2  = s2;
      in_imm   = imm;
      in_pc    = pc;
      up_credits--;
      issued++;
    end else begin
      in_valid = 1'b0;
    end
    // a returned credit is usable from the next cycle on
    if (in_credit) begin
      up_credits++;
      assert (up_credits <= QUEUE_DEPTH)
        else stop_on_error($sformatf("in_credit at %0t returned a credit never spent", $time));
    end
  endtask

  task automatic return_credits();
    res_credit = 1'b0;
    if (credit_delays.size() > 0 && credit_delays[0] == 0) begin
      credit_delays.delete(0);
      res_credit = 1'b1;
      block_credits++;
    end
    foreach (credit_delays[i]) begin
      if (credit_delays[i] > 0) credit_delays[i]--;
    end
  endtask

  initial begin
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_func    = func_none;
    in_src1    = '0;
    in_src2    = '0;
    in_imm     = '0;
    in_pc      = '0;
    res_credit = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) model_mem[i] = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    while (received < NUM_OPS) begin
      @(posedge clk);
      #1;
      check_result();
      drive_upstream();
      return_credits();
    end
    in_valid   = 1'b0;
    res_credit = 1'b0;
    // every popped entry hands its slot back to upstream
    if (up_credits == QUEUE_DEPTH) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      stop_on_error($sformatf("run ended with upstream holding %0d of %0d credits",
                              up_credits, QUEUE_DEPTH));
    end
  end

  // every op, even a divide under credit stalls, fits in the per-op budget
  initial begin
    #(WATCHDOG_NS);
    stop_on_error($sformatf("watchdog expired at %0t with %0d of %0d results received",
                            $time, received, NUM_OPS));
  end

endmodule

/* vlog.f */
+incdir+.
rv_exec_pkg.sv
op_queue.sv
exec_alu.sv
load_store_unit.sv
iter_divider.sv
div_step_counter.sv
exec_fsm.sv
exec_top.sv
tb_exec_top.sv
